/* include/rob_config.svh */
// Sizes are global macros; ROB_DEPTH must equal 2**ROB_IDX_LEN since the ROB pointers wrap freely
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Data path and instruction width
`define XLEN        32
`define ILEN        32

// Architectural register file
`define REG_IDX_LEN 5
`define NUM_AREGS   32

// Reorder buffer size
`define ROB_DEPTH   8
`define ROB_IDX_LEN 3

`endif

/* hdl/len5_pkg.sv */
// Integer ISA types only; the raw 4-bit cause field follows the RISC-V mcause numbering
`include "rob_config.svh"

package len5_pkg;

    // Architectural register index, x0 included
    typedef logic [`REG_IDX_LEN-1:0] reg_idx_t;

    // Synchronous exception causes
    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED   = 4'h0,
        E_I_ACCESS_FAULT      = 4'h1,
        E_ILLEGAL_INSTRUCTION = 4'h2,
        E_BREAKPOINT          = 4'h3,
        E_LD_ADDR_MISALIGNED  = 4'h4,
        E_LD_ACCESS_FAULT     = 4'h5,
        E_ST_ADDR_MISALIGNED  = 4'h6,
        E_ST_ACCESS_FAULT     = 4'h7,
        E_ENV_CALL_UMODE      = 4'h8,
        E_ENV_CALL_SMODE      = 4'h9,
        E_UNKNOWN             = 4'ha,  // Reserved slot, also the catch-all
        E_ENV_CALL_MMODE      = 4'hb,
        E_INSTR_PAGE_FAULT    = 4'hc,
        E_LD_PAGE_FAULT       = 4'hd,
        E_ST_PAGE_FAULT       = 4'hf
    } except_code_t;

endpackage

/* hdl/expipe_pkg.sv */
// Pipeline structs only; cause fields on issue and CDB are raw 4-bit codes, decoded once at commit
`include "rob_config.svh"

package expipe_pkg;

    // New instruction presented by the issue stage
    typedef struct packed {
        logic [`ILEN-1:0]   instr;
        logic [`XLEN-1:0]   pc;
        len5_pkg::reg_idx_t rd_idx;
        logic               except_raised;
        logic [3:0]         except_code;   // Raw cause
        logic [`XLEN-1:0]   except_aux;    // Bad address or early result
        logic               res_ready;     // Result known at issue
    } issue_req_t;

    // Result broadcast on the common data bus
    typedef struct packed {
        logic [`ROB_IDX_LEN-1:0] rob_idx;
        logic [`XLEN-1:0]        value;
        logic                    except_raised;
        logic [3:0]              except_code;
    } cdb_data_t;

    // One ROB slot
    typedef struct packed {
        logic               valid;
        logic               res_ready;
        logic [`ILEN-1:0]   instr;
        logic [`XLEN-1:0]   pc;
        len5_pkg::reg_idx_t rd_idx;
        logic [`XLEN-1:0]   value;
        logic               except_raised;
        logic [3:0]         except_code;
    } rob_entry_t;

    // Head entry as seen by the commit unit
    typedef struct packed {
        logic [`ILEN-1:0]        instr;
        logic [`XLEN-1:0]        pc;
        len5_pkg::reg_idx_t      rd_idx;
        logic [`XLEN-1:0]        value;
        logic                    except_raised;
        len5_pkg::except_code_t  except_code;
        logic [`ROB_IDX_LEN-1:0] head_idx;
    } commit_t;

    // Resolved source operand, tag meaningful only when not ready
    typedef struct packed {
        logic                    ready;
        logic [`XLEN-1:0]        value;
        logic [`ROB_IDX_LEN-1:0] tag;
    } operand_t;

    // Register status entry
    typedef struct packed {
        logic                    busy;
        logic [`ROB_IDX_LEN-1:0] rob_idx;
    } reg_stat_t;

endpackage

/* hdl/rob.sv */
// CDB writes are always accepted with no check of the target entry; no issue is taken during flush
`include "rob_config.svh"

module rob (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       issue_valid_i,
    input  expipe_pkg::issue_req_t     issue_req_i,
    output logic                       issue_ready_o,
    output logic [`ROB_IDX_LEN-1:0]    issue_tail_idx_o,
    input  logic                       cdb_valid_i,
    input  expipe_pkg::cdb_data_t      cdb_data_i,
    input  logic [`ROB_IDX_LEN-1:0]    rs1_tag_i,
    input  logic [`ROB_IDX_LEN-1:0]    rs2_tag_i,
    output logic                       rs1_ready_o,
    output logic                       rs2_ready_o,
    output logic [`XLEN-1:0]           rs1_value_o,
    output logic [`XLEN-1:0]           rs2_value_o,
    input  logic                       comm_ready_i,
    output logic                       comm_valid_o,
    output expipe_pkg::commit_t        comm_o
);

    expipe_pkg::rob_entry_t      rob_q [`ROB_DEPTH];
    logic [`ROB_IDX_LEN-1:0]     head_q;
    logic [`ROB_IDX_LEN-1:0]     tail_q;
    logic                        push;
    logic                        pop;
    len5_pkg::except_code_t      head_cause;

    // Tail slot free means room for one more
    assign issue_ready_o    = !rob_q[tail_q].valid && !flush_i;
    assign push             = issue_valid_i && issue_ready_o;
    assign issue_tail_idx_o = tail_q;

    // Head commits once its result is in
    assign comm_valid_o = rob_q[head_q].valid && rob_q[head_q].res_ready;
    assign pop          = comm_valid_o && comm_ready_i;

    // Pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push) tail_q <= tail_q + 1'b1;
            if (pop)  head_q <= head_q + 1'b1;
        end
    end

    // Entry array, status bits cleared on reset and flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_q[i].valid     <= 1'b0;
                rob_q[i].res_ready <= 1'b0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_q[i].valid     <= 1'b0;
                rob_q[i].res_ready <= 1'b0;
            end
        end else begin
            if (push) begin  // Allocation port
                rob_q[tail_q].valid         <= 1'b1;
                rob_q[tail_q].instr         <= issue_req_i.instr;
                rob_q[tail_q].pc            <= issue_req_i.pc;
                rob_q[tail_q].rd_idx        <= issue_req_i.rd_idx;
                rob_q[tail_q].except_raised <= issue_req_i.except_raised;
                rob_q[tail_q].except_code   <= issue_req_i.except_code;
                rob_q[tail_q].value         <= issue_req_i.except_aux;  // Aux parked as result
                rob_q[tail_q].res_ready     <= issue_req_i.except_raised
                                               || issue_req_i.res_ready;
            end
            if (cdb_valid_i) begin  // Result port
                rob_q[cdb_data_i.rob_idx].res_ready     <= 1'b1;
                rob_q[cdb_data_i.rob_idx].value         <= cdb_data_i.value;
                rob_q[cdb_data_i.rob_idx].except_raised <= cdb_data_i.except_raised;
                rob_q[cdb_data_i.rob_idx].except_code   <= cdb_data_i.except_code;
            end
            if (pop) rob_q[head_q].valid <= 1'b0;
        end
    end

    // Operand read ports, indexed by producer tag
    assign rs1_ready_o = rob_q[rs1_tag_i].res_ready;
    assign rs1_value_o = rob_q[rs1_tag_i].value;
    assign rs2_ready_o = rob_q[rs2_tag_i].res_ready;
    assign rs2_value_o = rob_q[rs2_tag_i].value;

    // Raw cause to enum, reserved codes fold into E_UNKNOWN
    always_comb begin
        case (rob_q[head_q].except_code)
            4'h0:    head_cause = len5_pkg::E_I_ADDR_MISALIGNED;
            4'h1:    head_cause = len5_pkg::E_I_ACCESS_FAULT;
            4'h2:    head_cause = len5_pkg::E_ILLEGAL_INSTRUCTION;
            4'h3:    head_cause = len5_pkg::E_BREAKPOINT;
            4'h4:    head_cause = len5_pkg::E_LD_ADDR_MISALIGNED;
            4'h5:    head_cause = len5_pkg::E_LD_ACCESS_FAULT;
            4'h6:    head_cause = len5_pkg::E_ST_ADDR_MISALIGNED;
            4'h7:    head_cause = len5_pkg::E_ST_ACCESS_FAULT;
            4'h8:    head_cause = len5_pkg::E_ENV_CALL_UMODE;
            4'h9:    head_cause = len5_pkg::E_ENV_CALL_SMODE;
            4'hb:    head_cause = len5_pkg::E_ENV_CALL_MMODE;
            4'hc:    head_cause = len5_pkg::E_INSTR_PAGE_FAULT;
            4'hd:    head_cause = len5_pkg::E_LD_PAGE_FAULT;
            4'hf:    head_cause = len5_pkg::E_ST_PAGE_FAULT;
            default: head_cause = len5_pkg::E_UNKNOWN;
        endcase
    end

    // Head entry out to commit
    always_comb begin
        comm_o.instr         = rob_q[head_q].instr;
        comm_o.pc            = rob_q[head_q].pc;
        comm_o.rd_idx        = rob_q[head_q].rd_idx;
        comm_o.value         = rob_q[head_q].value;
        comm_o.except_raised = rob_q[head_q].except_raised;
        comm_o.except_code   = head_cause;
        comm_o.head_idx      = head_q;
    end

endmodule

/* hdl/reg_status.sv */
// x0 is never marked busy; a commit clears a register only if no younger producer replaced it
`include "rob_config.svh"

module reg_status (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     alloc_i,
    input  len5_pkg::reg_idx_t       alloc_rd_i,
    input  logic [`ROB_IDX_LEN-1:0]  alloc_idx_i,
    input  logic                     commit_i,
    input  len5_pkg::reg_idx_t       commit_rd_i,
    input  logic [`ROB_IDX_LEN-1:0]  commit_idx_i,
    input  len5_pkg::reg_idx_t       rs1_idx_i,
    input  len5_pkg::reg_idx_t       rs2_idx_i,
    output expipe_pkg::reg_stat_t    rs1_stat_o,
    output expipe_pkg::reg_stat_t    rs2_stat_o
);

    logic [`NUM_AREGS-1:0]    busy_q;
    logic [`ROB_IDX_LEN-1:0]  idx_q [`NUM_AREGS];
    logic                     alloc_en;

    assign alloc_en = alloc_i && (alloc_rd_i != '0);  // Writes to x0 need no tracking

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else if (flush_i) begin
            busy_q <= '0;  // Every in-flight producer is gone
        end else begin
            if (commit_i && idx_q[commit_rd_i] == commit_idx_i) begin
                busy_q[commit_rd_i] <= 1'b0;
            end
            if (alloc_en) busy_q[alloc_rd_i] <= 1'b1;  // Last write, so allocation wins
        end
    end

    // Producer index
    always_ff @(posedge clk_i) begin
        if (alloc_en) idx_q[alloc_rd_i] <= alloc_idx_i;
    end

    assign rs1_stat_o = '{busy: busy_q[rs1_idx_i], rob_idx: idx_q[rs1_idx_i]};
    assign rs2_stat_o = '{busy: busy_q[rs2_idx_i], rob_idx: idx_q[rs2_idx_i]};

endmodule

/* hdl/operand_fetch.sv */
// Purely combinational; tags are forwarded unchanged and mean nothing when an operand is ready
`include "rob_config.svh"

module operand_fetch (
    input  len5_pkg::reg_idx_t      rs1_idx_i,
    input  len5_pkg::reg_idx_t      rs2_idx_i,
    input  expipe_pkg::reg_stat_t   rs1_stat_i,
    input  expipe_pkg::reg_stat_t   rs2_stat_i,
    input  logic                    rob_rs1_ready_i,
    input  logic                    rob_rs2_ready_i,
    input  logic [`XLEN-1:0]        rob_rs1_value_i,
    input  logic [`XLEN-1:0]        rob_rs2_value_i,
    input  logic [`XLEN-1:0]        rf_rs1_value_i,
    input  logic [`XLEN-1:0]        rf_rs2_value_i,
    output expipe_pkg::operand_t    op1_o,
    output expipe_pkg::operand_t    op2_o
);

    // Priority x0, register file, ROB result, else wait on tag
    function automatic expipe_pkg::operand_t resolve(
        input len5_pkg::reg_idx_t    idx,
        input expipe_pkg::reg_stat_t stat,
        input logic                  rob_ready,
        input logic [`XLEN-1:0]      rob_value,
        input logic [`XLEN-1:0]      rf_value
    );
        expipe_pkg::operand_t op;
        op.tag = stat.rob_idx;
        if (idx == '0) begin
            op.ready = 1'b1;
            op.value = '0;
        end else if (!stat.busy) begin
            op.ready = 1'b1;
            op.value = rf_value;
        end else begin
            op.ready = rob_ready;  // Forward from ROB once written
            op.value = rob_value;
        end
        return op;
    endfunction

    assign op1_o = resolve(rs1_idx_i, rs1_stat_i, rob_rs1_ready_i, rob_rs1_value_i,
                           rf_rs1_value_i);
    assign op2_o = resolve(rs2_idx_i, rs2_stat_i, rob_rs2_ready_i, rob_rs2_value_i,
                           rf_rs2_value_i);

endmodule

/* hdl/commit_unit.sv */
// Exception capture holds the last exception until the next one; no trap vectoring or CSR writes
`include "rob_config.svh"

module commit_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     comm_valid_i,
    input  expipe_pkg::commit_t      comm_i,
    output logic                     comm_ready_o,
    input  len5_pkg::reg_idx_t       rf_rs1_idx_i,
    input  len5_pkg::reg_idx_t       rf_rs2_idx_i,
    output logic [`XLEN-1:0]         rf_rs1_value_o,
    output logic [`XLEN-1:0]         rf_rs2_value_o,
    output logic                     flush_o,
    output logic                     except_valid_o,
    output logic [`XLEN-1:0]         except_pc_o,
    output logic [`XLEN-1:0]         except_aux_o,
    output len5_pkg::except_code_t   except_cause_o
);

    logic [`XLEN-1:0]  rf_q [`NUM_AREGS];
    logic              flush_q;
    logic              commit;
    logic              take_except;

    assign comm_ready_o = !flush_q;  // Nothing retires while the pipe is flushed
    assign commit       = comm_valid_i && comm_ready_o;
    assign take_except  = commit && comm_i.except_raised;
    assign flush_o      = flush_q;

    // Flush pulse one cycle after the faulting commit, sticky valid flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flush_q        <= 1'b0;
            except_valid_o <= 1'b0;
        end else begin
            flush_q <= take_except;
            if (take_except) except_valid_o <= 1'b1;
        end
    end

    // Cause, pc and aux captured together
    always_ff @(posedge clk_i) begin
        if (take_except) begin
            except_pc_o    <= comm_i.pc;
            except_cause_o <= comm_i.except_code;
            except_aux_o   <= comm_i.value;  // Aux travels in the result field
        end
    end

    // Register file, x0 stays zero since it is never written
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_AREGS; i++) rf_q[i] <= '0;
        end else if (commit && !comm_i.except_raised && comm_i.rd_idx != '0) begin
            rf_q[comm_i.rd_idx] <= comm_i.value;
        end
    end

    assign rf_rs1_value_o = rf_q[rf_rs1_idx_i];
    assign rf_rs2_value_o = rf_q[rf_rs2_idx_i];

endmodule

/* hdl/rob_subsys.sv */
// CDB has no back-pressure and must carry a valid ROB index; operands resolve in the lookup cycle
`include "rob_config.svh"

module rob_subsys (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       issue_valid_i,
    input  expipe_pkg::issue_req_t     issue_req_i,
    output logic                       issue_ready_o,
    output logic [`ROB_IDX_LEN-1:0]    issue_tail_idx_o,
    input  logic                       cdb_valid_i,
    input  expipe_pkg::cdb_data_t      cdb_data_i,
    input  len5_pkg::reg_idx_t         rs1_idx_i,
    input  len5_pkg::reg_idx_t         rs2_idx_i,
    output expipe_pkg::operand_t       op1_o,
    output expipe_pkg::operand_t       op2_o,
    output logic                       flush_o,
    output logic                       except_valid_o,
    output logic [`XLEN-1:0]           except_pc_o,
    output len5_pkg::except_code_t     except_cause_o,
    output logic [`XLEN-1:0]           except_aux_o
);

    logic                    comm_valid;
    logic                    comm_ready;
    expipe_pkg::commit_t     comm;
    expipe_pkg::reg_stat_t   rs1_stat;
    expipe_pkg::reg_stat_t   rs2_stat;
    logic                    rob_rs1_ready;
    logic                    rob_rs2_ready;
    logic [`XLEN-1:0]        rob_rs1_value;
    logic [`XLEN-1:0]        rob_rs2_value;
    logic [`XLEN-1:0]        rf_rs1_value;
    logic [`XLEN-1:0]        rf_rs2_value;

    rob u_rob (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_o),
        .issue_valid_i    (issue_valid_i),
        .issue_req_i      (issue_req_i),
        .issue_ready_o    (issue_ready_o),
        .issue_tail_idx_o (issue_tail_idx_o),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_data_i       (cdb_data_i),
        .rs1_tag_i        (rs1_stat.rob_idx),   // Producer tags from status table
        .rs2_tag_i        (rs2_stat.rob_idx),
        .rs1_ready_o      (rob_rs1_ready),
        .rs2_ready_o      (rob_rs2_ready),
        .rs1_value_o      (rob_rs1_value),
        .rs2_value_o      (rob_rs2_value),
        .comm_ready_i     (comm_ready),
        .comm_valid_o     (comm_valid),
        .comm_o           (comm)
    );

    reg_status u_reg_status (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_o),
        .alloc_i      (issue_valid_i && issue_ready_o),  // Same edge as ROB allocation
        .alloc_rd_i   (issue_req_i.rd_idx),
        .alloc_idx_i  (issue_tail_idx_o),
        .commit_i     (comm_valid && comm_ready),
        .commit_rd_i  (comm.rd_idx),
        .commit_idx_i (comm.head_idx),
        .rs1_idx_i    (rs1_idx_i),
        .rs2_idx_i    (rs2_idx_i),
        .rs1_stat_o   (rs1_stat),
        .rs2_stat_o   (rs2_stat)
    );

    operand_fetch u_operand_fetch (
        .rs1_idx_i       (rs1_idx_i),
        .rs2_idx_i       (rs2_idx_i),
        .rs1_stat_i      (rs1_stat),
        .rs2_stat_i      (rs2_stat),
        .rob_rs1_ready_i (rob_rs1_ready),
        .rob_rs2_ready_i (rob_rs2_ready),
        .rob_rs1_value_i (rob_rs1_value),
        .rob_rs2_value_i (rob_rs2_value),
        .rf_rs1_value_i  (rf_rs1_value),
        .rf_rs2_value_i  (rf_rs2_value),
        .op1_o           (op1_o),
        .op2_o           (op2_o)
    );

    commit_unit u_commit_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .comm_valid_i   (comm_valid),
        .comm_i         (comm),
        .comm_ready_o   (comm_ready),
        .rf_rs1_idx_i   (rs1_idx_i),
        .rf_rs2_idx_i   (rs2_idx_i),
        .rf_rs1_value_o (rf_rs1_value),
        .rf_rs2_value_o (rf_rs2_value),
        .flush_o        (flush_o),
        .except_valid_o (except_valid_o),
        .except_pc_o    (except_pc_o),
        .except_aux_o   (except_aux_o),
        .except_cause_o (except_cause_o)
    );

endmodule

/* testbench/tb_clkgen.sv */
// Clock runs from time zero; reset is released on a falling edge after three rising edges
module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o) rst_n_o = 1'b1;  // Away from the active edge
    end
endmodule

/* testbench/rob_props.sv */
// Bound into every rob instance; flush and comm_ready there are the commit unit's outputs
`include "rob_config.svh"

module rob_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic flush_i,
    input logic issue_valid_i,
    input logic issue_ready_i,
    input logic commit_i,
    input logic comm_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`ROB_IDX_LEN:0] occupancy_q;     // Entries in flight, from the issue and commit handshakes
    int                    fail_count = 0;  // Failed assertions so far

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupancy_q <= '0;
        end else if (flush_i) begin
            occupancy_q <= '0;  // Flush empties the ROB
        end else begin
            occupancy_q <= occupancy_q + (issue_valid_i && issue_ready_i) - commit_i;
        end
    end

    // Retiring an empty slot would write stale data
    a_commit_head_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_i |-> occupancy_q != '0) else begin
        $error("commit taken from an empty ROB");
        fail_count++;
    end

    a_flush_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !flush_i) else begin
        $error("flush held longer than one cycle");
        fail_count++;
    end

    a_full_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        occupancy_q == `ROB_DEPTH |-> !issue_ready_i) else begin
        $error("issue_ready high while the ROB is full");
        fail_count++;
    end

    a_flush_blocks_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !comm_ready_i) else begin
        $error("comm_ready high during flush");
        fail_count++;
    end
endmodule

bind rob rob_props u_rob_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_i (issue_ready_o),
    .commit_i      (comm_valid_o && comm_ready_i),
    .comm_ready_i  (comm_ready_i)
);

/* testbench/tb_rob_subsys.sv */
// One exception scenario with a fixed cause; ROB indices in the table assume allocation from reset
`include "rob_config.svh"

module tb_rob_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [2:0]  act_issue = 3'd0;
    localparam logic [2:0]  act_cdb   = 3'd1;
    localparam logic [2:0]  act_look  = 3'd2;
    localparam logic [2:0]  act_idle  = 3'd3;
    localparam logic [2:0]  act_flush = 3'd4;       // Idle until flush_o pulses
    localparam logic [3:0]  exc_code  = 4'h2;       // Illegal instruction
    localparam logic [31:0] pc_base   = 32'h0000_1000;

    typedef struct packed {
        logic [2:0]              act;
        logic [2:0]              test;
        logic                    chk_rdy;           // Compare issue_ready_o
        logic                    exp_rdy;
        logic                    chk_exc;           // Compare exception capture
        logic                    exc;
        logic                    flag;              // Ready at issue, or op1 ready expected
        len5_pkg::reg_idx_t      reg_idx;           // rd on issue, rs1 on lookup
        logic [`ROB_IDX_LEN-1:0] rob_idx;           // CDB target, expected tag or tail entry
        logic [`XLEN-1:0]        val;               // Aux, CDB value or expected operand
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    issue_valid;
    expipe_pkg::issue_req_t  issue_req;
    logic                    issue_ready;
    logic [`ROB_IDX_LEN-1:0] tail_idx;
    logic                    cdb_valid;
    expipe_pkg::cdb_data_t   cdb_data;
    len5_pkg::reg_idx_t      rs1_idx;
    len5_pkg::reg_idx_t      rs2_idx;
    expipe_pkg::operand_t    op1;
    expipe_pkg::operand_t    op2;
    logic                    flush;
    logic                    except_valid;
    logic [`XLEN-1:0]        except_pc;
    logic [`XLEN-1:0]        except_aux;
    len5_pkg::except_code_t  except_cause;

    row_t        rows [64];
    int          n_rows = 0;
    int          errors = 0;
    int          asrt_fails = 0;
    int          cycles = 0;
    int          limit = 0;
    int          cur_test = 0;
    logic [31:0] seed = 32'h85e7_6e94;
    logic [31:0] exp_pc;
    logic [31:0] exp_aux;
    string       test_names [6] = '{"reset", "ready_at_issue", "ooo_complete", "rob_full",
                                    "exception_flush", "x0_write"};

    tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    rob_subsys DUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .issue_valid_i(issue_valid), .issue_req_i(issue_req),
        .issue_ready_o(issue_ready), .issue_tail_idx_o(tail_idx),
        .cdb_valid_i(cdb_valid), .cdb_data_i(cdb_data),
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .op1_o(op1), .op2_o(op2),
        .flush_o(flush), .except_valid_o(except_valid), .except_pc_o(except_pc),
        .except_cause_o(except_cause), .except_aux_o(except_aux)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input logic [2:0] act, input logic [4:0] r,
                           input logic [2:0] idx, input logic [31:0] val, input logic flag);
        row_t row;
        row = '0;
        row.act = act;
        row.test = cur_test[2:0];
        row.reg_idx = r;
        row.rob_idx = idx;
        row.val = val;
        row.flag = flag;
        rows[n_rows] = row;
        n_rows++;
    endtask

    task automatic expect_issue_ready(input logic b);
        rows[n_rows-1].chk_rdy = 1'b1;
        rows[n_rows-1].exp_rdy = b;
    endtask

    task automatic raise_exception();  // Last row faults, capture values follow from it
        rows[n_rows-1].exc = 1'b1;
        exp_pc = pc_base + 32'((n_rows - 1) * 4);
        exp_aux = rows[n_rows-1].val;
    endtask

    task automatic build_table();
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] v;
        cur_test = 1;
        seed = lcg_next(seed);
        add_row(act_issue, 5'd1, 3'd0, seed, 1'b1);  // ROB entry 0, result at issue
        expect_issue_ready(1'b1);
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);  // Commit edge
        add_row(act_look, 5'd1, 3'd0, seed, 1'b1);
        cur_test = 2;
        va = lcg_next(seed);
        vb = lcg_next(va);
        seed = vb;
        add_row(act_issue, 5'd3, 3'd1, 32'd0, 1'b0);  // A in entry 1
        add_row(act_issue, 5'd5, 3'd2, 32'd0, 1'b0);  // B in entry 2
        add_row(act_cdb, 5'd0, 3'd2, vb, 1'b0);
        add_row(act_look, 5'd5, 3'd0, vb, 1'b1);      // Forwarded from the ROB
        add_row(act_look, 5'd3, 3'd1, 32'd0, 1'b0);   // Waits on A's tag
        add_row(act_cdb, 5'd0, 3'd1, va, 1'b0);
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);   // A retires
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);   // B retires
        add_row(act_look, 5'd3, 3'd0, va, 1'b1);
        add_row(act_look, 5'd5, 3'd0, vb, 1'b1);
        cur_test = 3;
        for (int k = 0; k < `ROB_DEPTH; k++) begin    // Entries 3..7 then 0..2
            add_row(act_issue, 5'(8 + k), 3'((3 + k) % `ROB_DEPTH), 32'd0, 1'b0);
            expect_issue_ready(1'b1);
        end
        add_row(act_issue, 5'd20, 3'd3, 32'd0, 1'b0); // Tail stays on entry 3
        expect_issue_ready(1'b0);                     // Full, dropped
        add_row(act_look, 5'd20, 3'd0, 32'd0, 1'b1);  // x20 never went busy
        seed = lcg_next(seed);
        add_row(act_cdb, 5'd0, 3'd3, seed, 1'b0);     // Head completes
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);
        expect_issue_ready(1'b0);                     // Still full until the commit edge
        add_row(act_issue, 5'd21, 3'd3, 32'd0, 1'b0);
        expect_issue_ready(1'b1);                     // Reuses entry 3
        add_row(act_look, 5'd8, 3'd0, seed, 1'b1);
        for (int k = 1; k <= `ROB_DEPTH; k++) begin   // Drain in order, entry 3 last
            seed = lcg_next(seed);
            add_row(act_cdb, 5'd0, 3'((3 + k) % `ROB_DEPTH), seed, 1'b0);
        end
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);
        add_row(act_look, 5'd21, 3'd0, seed, 1'b1);
        cur_test = 4;
        seed = lcg_next(seed);
        add_row(act_issue, 5'd7, 3'd4, seed, 1'b0);   // Fault alone marks it ready
        raise_exception();
        add_row(act_issue, 5'd3, 3'd5, 32'd0, 1'b0);  // Younger, issued on the fault's commit
        expect_issue_ready(1'b1);
        add_row(act_flush, 5'd0, 3'd0, 32'd0, 1'b0);
        add_row(act_look, 5'd3, 3'd0, va, 1'b1);      // Old value, busy bit gone
        expect_issue_ready(1'b1);
        rows[n_rows-1].chk_exc = 1'b1;
        add_row(act_look, 5'd7, 3'd0, 32'd0, 1'b1);   // Faulting rd untouched
        cur_test = 5;
        v = lcg_next(seed);
        add_row(act_issue, 5'd0, 3'd0, v, 1'b1);      // Pointers back at entry 0 after flush
        add_row(act_idle, 5'd0, 3'd0, 32'd0, 1'b0);
        add_row(act_look, 5'd0, 3'd0, 32'd0, 1'b1);
    endtask

    task automatic drive_row(input row_t row, input int i);
        issue_valid = (row.act == act_issue);
        issue_req.instr = {20'd0, row.reg_idx, 7'h13};  // ALU-immediate form
        issue_req.pc = pc_base + 32'(i * 4);
        issue_req.rd_idx = row.reg_idx;
        issue_req.except_raised = row.exc;
        issue_req.except_code = row.exc ? exc_code : 4'h0;
        issue_req.except_aux = row.val;
        issue_req.res_ready = row.flag;
        cdb_valid = (row.act == act_cdb);
        cdb_data = '{rob_idx: row.rob_idx, value: row.val, except_raised: 1'b0,
                     except_code: 4'h0};
        rs1_idx = (row.act == act_look) ? row.reg_idx : 5'd0;
        rs2_idx = 5'd0;  // x0 probed on every row
    endtask

    task automatic mismatch(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s %s: expected %h actual %h", name, what, exp, act);
        errors++;
    endtask

    task automatic check_row(input row_t row);
        string name;
        name = test_names[row.test];
        if (row.chk_rdy && issue_ready !== row.exp_rdy)
            mismatch(name, "issue_ready", row.exp_rdy, issue_ready);
        if (row.act == act_issue && tail_idx !== row.rob_idx)
            mismatch(name, "tail_idx", row.rob_idx, tail_idx);
        if (row.act == act_look) begin
            if (op1.ready !== row.flag) mismatch(name, "op1 ready", row.flag, op1.ready);
            else if (row.flag && op1.value !== row.val)
                mismatch(name, "op1 value", row.val, op1.value);
            else if (!row.flag && op1.tag !== row.rob_idx)
                mismatch(name, "op1 tag", row.rob_idx, op1.tag);
            if (op2.ready !== 1'b1) mismatch(name, "x0 ready", 32'd1, op2.ready);
            if (op2.value !== '0) mismatch(name, "x0 value", 32'd0, op2.value);
        end
        if (row.chk_exc) begin
            if (except_valid !== 1'b1) mismatch(name, "except_valid", 32'd1, except_valid);
            if (except_pc !== exp_pc) mismatch(name, "except_pc", exp_pc, except_pc);
            if (except_cause !== len5_pkg::E_ILLEGAL_INSTRUCTION)
                mismatch(name, "except_cause", len5_pkg::E_ILLEGAL_INSTRUCTION, except_cause);
            if (except_aux !== exp_aux) mismatch(name, "except_aux", exp_aux, except_aux);
        end
    endtask

    initial begin
        issue_valid = 1'b0;
        issue_req = '0;
        cdb_valid = 1'b0;
        cdb_data = '0;
        rs1_idx = '0;
        rs2_idx = '0;
        build_table();
        limit = n_rows * 4 + 20;
        @(posedge rst_n);
        #1;
        if (issue_ready !== 1'b1) mismatch(test_names[0], "issue_ready", 32'd1, issue_ready);
        if (flush !== 1'b0) mismatch(test_names[0], "flush", 32'd0, flush);
        if (except_valid !== 1'b0) mismatch(test_names[0], "except_valid", 32'd0, except_valid);
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            drive_row(rows[i], i);
            #1;
            while (rows[i].act == act_flush && flush !== 1'b1) begin  // Handshake wait
                @(negedge clk);
                #1;
            end
            check_row(rows[i]);
        end
        asrt_fails = DUT.u_rob.u_rob_props.fail_count;
        $display("%0d rows applied, %0d check errors, %0d assertion failures",
                 n_rows, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog, limit scales with the table
    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end
endmodule

/* build.f */
+incdir+include
hdl/len5_pkg.sv
hdl/expipe_pkg.sv
hdl/rob.sv
hdl/reg_status.sv
hdl/operand_fetch.sv
hdl/commit_unit.sv
hdl/rob_subsys.sv
testbench/tb_clkgen.sv
testbench/rob_props.sv
testbench/tb_rob_subsys.sv
